// ==== common/pixel_pkg.sv ====
// Pixel test stand shared definitions
// ASIC pin bundles, host register port structs, chain word types,
// register map and lane numbering used by the firmware blocks
`default_nettype none

package pixel_pkg;

  // ----------------------------------------------------------
  // ASIC pin bundles
  // ----------------------------------------------------------
  typedef struct packed {
    logic super_pixel_sel;
    logic config_clk;
    logic reset_not;
    logic config_in;
    logic config_load;
    logic bxclk_ana;
    logic bxclk;               // Scan chain shift clock
    logic vin_test_trig_out;
    logic scan_in;
    logic scan_load;
  } dut_out_t;

  typedef struct packed {
    logic config_out;
    logic scan_out;
    logic dnn_output_0;
    logic dnn_output_1;
    logic dn_event_toggle;
  } dut_in_t;

  // Chain words
  typedef logic [31:0] cfg_word_t;
  typedef logic [15:0] scan_word_t;

  // ----------------------------------------------------------
  // Host register port
  // ----------------------------------------------------------
  typedef struct packed {
    logic        wr;
    logic [2:0]  addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic [31:0] rdata;
  } reg_rsp_t;

  typedef enum logic {
    CHAIN_CONFIG,
    CHAIN_SCAN
  } chain_sel_e;

  // Register map
  localparam logic [2:0] REG_OWNER     = 3'd0;
  localparam logic [2:0] REG_MANUAL    = 3'd1;
  localparam logic [2:0] REG_PIN_IN    = 3'd2;  // Read only
  localparam logic [2:0] REG_CFG_DATA  = 3'd3;
  localparam logic [2:0] REG_SCAN_DATA = 3'd4;
  localparam logic [2:0] REG_STATUS    = 3'd5;

  // Lane numbering on the pin mux
  localparam int LANE_MANUAL = 0;
  localparam int LANE_CONFIG = 1;
  localparam int LANE_SCAN   = 2;

  localparam int BIT_CYCLES = 4;  // fw_clk cycles per chain bit

endpackage

`default_nettype wire

// ==== chain_engine/chain_shifter.sv ====
// Serial chain shifter
// Shifts one word into an ASIC chain MSB first while capturing the bits
// that come back, then pulses the chain load pin and returns the old
// chain content as the response
`timescale 1ns/10ps
`default_nettype none

module chain_shifter import pixel_pkg::*; #(
  parameter type        word_t = cfg_word_t,
  parameter chain_sel_e CHAIN  = CHAIN_CONFIG
) (
  input  logic     fw_clk,
  input  logic     fw_rst_n,
  // Command in, captured word out
  input  word_t    cmd,
  input  logic     cmd_valid,
  output logic     cmd_ready,
  output word_t    rsp,
  output logic     rsp_valid,
  output logic     busy,
  // Lane pins through the mux
  output dut_out_t lane_out,
  input  dut_in_t  lane_in
);

  localparam int W    = $bits(word_t);
  localparam int PH_W = $clog2(BIT_CYCLES);
  localparam int BC_W = $clog2(W);
  localparam logic [PH_W-1:0] PH_LAST  = PH_W'(BIT_CYCLES - 1);
  localparam logic [BC_W-1:0] BIT_LAST = BC_W'(W - 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SHIFT,
    ST_LOAD,
    ST_DONE
  } state_e;

  state_e          state;
  logic [PH_W-1:0] phase;      // Position inside one bit slot
  logic [BC_W-1:0] bit_cnt;
  logic            busy_q;
  logic            cmd_fire;
  logic            phase_end;
  word_t           sh_q;       // Outgoing bits, MSB leaves first
  word_t           cap_q;      // Bits returned by the chain
  logic            ret_bit;
  logic            ser_data;
  logic            ser_clk;
  logic            ser_load;

  assign cmd_fire  = cmd_valid && cmd_ready;
  assign phase_end = (phase == PH_LAST);
  assign ret_bit   = (CHAIN == CHAIN_CONFIG) ? lane_in.config_out : lane_in.scan_out;

  // ----------------------------------------------------------
  // Sequencer
  // ----------------------------------------------------------
  always_ff @(posedge fw_clk) begin
    if (!fw_rst_n) begin
      state   <= ST_IDLE;
      phase   <= '0;
      bit_cnt <= '0;
      busy_q  <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (cmd_fire) begin
            state   <= ST_SHIFT;
            phase   <= '0;
            bit_cnt <= '0;
            busy_q  <= 1'b1;
          end
        end
        ST_SHIFT: begin
          phase <= phase_end ? '0 : phase + 1'b1;
          if (phase_end) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == BIT_LAST)
              state <= ST_LOAD;   // Last bit done
          end
        end
        ST_LOAD: begin
          phase <= phase_end ? '0 : phase + 1'b1;
          if (phase_end)
            state <= ST_DONE;
        end
        ST_DONE: begin
          state  <= ST_IDLE;
          busy_q <= 1'b0;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Shift and capture registers
  always_ff @(posedge fw_clk) begin
    if (cmd_fire)
      sh_q <= cmd;
    else if (state == ST_SHIFT && phase_end)
      sh_q <= word_t'({sh_q[W-2:0], 1'b0});
    if (state == ST_SHIFT && phase == '0)
      cap_q <= word_t'({cap_q[W-2:0], ret_bit});   // Sample before the clock edge
  end

  // ----------------------------------------------------------
  // Pin drive
  // ----------------------------------------------------------
  assign ser_data = (state == ST_SHIFT) && sh_q[W-1];
  assign ser_clk  = (state == ST_SHIFT) && (phase != '0) && !phase_end;
  assign ser_load = (state == ST_LOAD);

  always_comb begin
    lane_out = '0;   // Pins of the other chain stay low
    if (CHAIN == CHAIN_CONFIG) begin
      lane_out.config_in   = ser_data;
      lane_out.config_clk  = ser_clk;
      lane_out.config_load = ser_load;
    end else begin
      lane_out.scan_in   = ser_data;
      lane_out.bxclk     = ser_clk;
      lane_out.scan_load = ser_load;
    end
  end

  assign cmd_ready = (state == ST_IDLE);
  assign busy      = busy_q;
  assign rsp_valid = (state == ST_DONE);
  assign rsp       = cap_q;

  // Registered busy flag must track the sequencer
  ready_busy_a : assert property (@(posedge fw_clk) disable iff (!fw_rst_n)
    !(cmd_ready && busy));

endmodule

`default_nettype wire

// ==== design/pixel_reg_block.sv ====
// Pixel firmware register block
// Decodes host register accesses, holds the lane owner and manual pin
// registers, launches chain shifts and returns one response per request
`timescale 1ns/10ps
`default_nettype none

module pixel_reg_block import pixel_pkg::*; #(
  parameter int N_FW = 3
) (
  input  logic            fw_clk,
  input  logic            fw_rst_n,
  // Host request / response
  input  reg_req_t        reg_req,
  input  logic            reg_req_valid,
  output logic            reg_req_ready,
  output reg_rsp_t        reg_rsp,
  output logic            reg_rsp_valid,
  input  logic            reg_rsp_ready,
  // Pin mux control and lane 0
  output logic [N_FW-1:0] owner,
  output dut_out_t        manual_out,
  input  dut_in_t         manual_in,
  // Configuration chain shifter
  output cfg_word_t       cfg_cmd,
  output logic            cfg_cmd_valid,
  input  logic            cfg_cmd_ready,
  input  cfg_word_t       cfg_rsp,
  input  logic            cfg_rsp_valid,
  input  logic            cfg_busy,
  // Scan chain shifter
  output scan_word_t      scan_cmd,
  output logic            scan_cmd_valid,
  input  logic            scan_cmd_ready,
  input  scan_word_t      scan_rsp,
  input  logic            scan_rsp_valid,
  input  logic            scan_busy
);

  logic        slot_free;   // Response register free this cycle
  logic        is_cfg_wr;
  logic        is_scan_wr;
  logic        req_fire;
  logic [31:0] rd_data;
  cfg_word_t   cfg_capture;
  scan_word_t  scan_capture;

  // ----------------------------------------------------------
  // Handshake and shift launch
  // ----------------------------------------------------------
  assign slot_free  = !reg_rsp_valid || reg_rsp_ready;
  assign is_cfg_wr  = reg_req.wr && (reg_req.addr == REG_CFG_DATA);
  assign is_scan_wr = reg_req.wr && (reg_req.addr == REG_SCAN_DATA);

  // Data writes stall until the shifter takes the word
  assign reg_req_ready = slot_free && !(is_cfg_wr && !cfg_cmd_ready)
                         && !(is_scan_wr && !scan_cmd_ready);
  assign req_fire      = reg_req_valid && reg_req_ready;

  assign cfg_cmd        = reg_req.wdata;
  assign cfg_cmd_valid  = reg_req_valid && is_cfg_wr && slot_free;
  assign scan_cmd       = reg_req.wdata[$bits(scan_word_t)-1:0];
  assign scan_cmd_valid = reg_req_valid && is_scan_wr && slot_free;

  // Read data
  always_comb begin
    case (reg_req.addr)
      REG_OWNER:     rd_data = 32'(owner);
      REG_MANUAL:    rd_data = 32'(manual_out);
      REG_PIN_IN:    rd_data = 32'(manual_in);
      REG_CFG_DATA:  rd_data = cfg_capture;
      REG_SCAN_DATA: rd_data = 32'(scan_capture);
      REG_STATUS:    rd_data = {30'd0, scan_busy, cfg_busy};
      default:       rd_data = 32'd0;
    endcase
  end

  // ----------------------------------------------------------
  // Control registers
  // ----------------------------------------------------------
  always_ff @(posedge fw_clk) begin
    if (!fw_rst_n) begin
      owner         <= '0;
      manual_out    <= '0;
      reg_rsp_valid <= 1'b0;
    end else begin
      if (req_fire && reg_req.wr && reg_req.addr == REG_OWNER)
        owner <= reg_req.wdata[N_FW-1:0];
      if (req_fire && reg_req.wr && reg_req.addr == REG_MANUAL)
        manual_out <= dut_out_t'(reg_req.wdata[$bits(dut_out_t)-1:0]);
      if (req_fire)
        reg_rsp_valid <= 1'b1;
      else if (reg_rsp_ready)
        reg_rsp_valid <= 1'b0;   // Response taken, slot empty
    end
  end

  // Response payload and captured chain words
  always_ff @(posedge fw_clk) begin
    if (req_fire)
      reg_rsp.rdata <= reg_req.wr ? 32'd0 : rd_data;
    if (cfg_rsp_valid)
      cfg_capture <= cfg_rsp;
    if (scan_rsp_valid)
      scan_capture <= scan_rsp;
  end

  // A pending response stays put until the host takes it
  rsp_hold_a : assert property (@(posedge fw_clk) disable iff (!fw_rst_n)
    reg_rsp_valid && !reg_rsp_ready |=> reg_rsp_valid && $stable(reg_rsp));

endmodule

`default_nettype wire

// ==== design/fw_pin_mux.sv ====
// Firmware lane pin mux
// Routes the pins of the owning lane to the ASIC through output pad
// registers and returns the registered ASIC inputs to that lane only
`timescale 1ns/10ps
`default_nettype none

module fw_pin_mux import pixel_pkg::*; #(
  parameter int N_FW = 3
) (
  input  logic            fw_clk,
  input  logic            fw_rst_n,
  input  logic [N_FW-1:0] owner,              // One-hot lane select
  input  dut_out_t        lane_out [N_FW],
  output dut_in_t         lane_in  [N_FW],
  output dut_out_t        pins_out,
  input  dut_in_t         pins_in
);

  logic     owner_ok;
  dut_out_t out_sel;
  dut_in_t  pins_in_q;   // Input pad register

  assign owner_ok = $onehot(owner);

  // ----------------------------------------------------------
  // Output path
  // ----------------------------------------------------------
  always_comb begin
    out_sel = '0;
    if (owner_ok) begin
      for (int i = 0; i < N_FW; i++) begin
        if (owner[i])
          out_sel = lane_out[i];
      end
    end
  end

  // Output pad register
  always_ff @(posedge fw_clk) begin
    if (!fw_rst_n)
      pins_out <= '0;
    else
      pins_out <= out_sel;
  end

  // ----------------------------------------------------------
  // Input path
  // ----------------------------------------------------------
  always_ff @(posedge fw_clk) begin
    if (!fw_rst_n)
      pins_in_q <= '0;
    else
      pins_in_q <= pins_in;
  end

  // Fan out to the owner, zero elsewhere
  always_comb begin
    for (int i = 0; i < N_FW; i++) begin
      lane_in[i] = (owner_ok && owner[i]) ? pins_in_q : '0;
    end
  end

  // Bad owner must park every ASIC pin low
  pins_idle_a : assert property (@(posedge fw_clk) disable iff (!fw_rst_n)
    !owner_ok |=> pins_out == '0);

endmodule

`default_nettype wire

// ==== design/pixel_fw_top.sv ====
// Pixel test stand firmware top
// Register block, configuration and scan chain shifters and the lane
// pin mux between the firmware and the ASIC pins
`timescale 1ns/10ps
`default_nettype none

module pixel_fw_top import pixel_pkg::*; (
  input  logic     fw_clk,
  input  logic     fw_rst_n,
  // Host port
  input  reg_req_t reg_req,
  input  logic     reg_req_valid,
  output logic     reg_req_ready,
  output reg_rsp_t reg_rsp,
  output logic     reg_rsp_valid,
  input  logic     reg_rsp_ready,
  // ASIC pins
  output dut_out_t dut_out,
  input  dut_in_t  dut_in
);

  localparam int N_FW = 3;   // Manual, config and scan lanes

  logic [N_FW-1:0] owner;
  dut_out_t        lane_out [N_FW];
  dut_in_t         lane_in  [N_FW];

  cfg_word_t  cfg_cmd;
  cfg_word_t  cfg_rsp;
  logic       cfg_cmd_valid;
  logic       cfg_cmd_ready;
  logic       cfg_rsp_valid;
  logic       cfg_busy;
  scan_word_t scan_cmd;
  scan_word_t scan_rsp;
  logic       scan_cmd_valid;
  logic       scan_cmd_ready;
  logic       scan_rsp_valid;
  logic       scan_busy;

  // ----------------------------------------------------------
  // Register block drives lane 0 directly
  // ----------------------------------------------------------
  pixel_reg_block #(.N_FW(N_FW)) u_regs (
    .fw_clk         (fw_clk),
    .fw_rst_n       (fw_rst_n),
    .reg_req        (reg_req),
    .reg_req_valid  (reg_req_valid),
    .reg_req_ready  (reg_req_ready),
    .reg_rsp        (reg_rsp),
    .reg_rsp_valid  (reg_rsp_valid),
    .reg_rsp_ready  (reg_rsp_ready),
    .owner          (owner),
    .manual_out     (lane_out[LANE_MANUAL]),
    .manual_in      (lane_in[LANE_MANUAL]),
    .cfg_cmd        (cfg_cmd),
    .cfg_cmd_valid  (cfg_cmd_valid),
    .cfg_cmd_ready  (cfg_cmd_ready),
    .cfg_rsp        (cfg_rsp),
    .cfg_rsp_valid  (cfg_rsp_valid),
    .cfg_busy       (cfg_busy),
    .scan_cmd       (scan_cmd),
    .scan_cmd_valid (scan_cmd_valid),
    .scan_cmd_ready (scan_cmd_ready),
    .scan_rsp       (scan_rsp),
    .scan_rsp_valid (scan_rsp_valid),
    .scan_busy      (scan_busy)
  );

  chain_shifter #(.word_t(cfg_word_t), .CHAIN(CHAIN_CONFIG)) u_cfg_shift (
    .fw_clk    (fw_clk),
    .fw_rst_n  (fw_rst_n),
    .cmd       (cfg_cmd),
    .cmd_valid (cfg_cmd_valid),
    .cmd_ready (cfg_cmd_ready),
    .rsp       (cfg_rsp),
    .rsp_valid (cfg_rsp_valid),
    .busy      (cfg_busy),
    .lane_out  (lane_out[LANE_CONFIG]),
    .lane_in   (lane_in[LANE_CONFIG])
  );

  // Scan chain shifts on bxclk
  chain_shifter #(.word_t(scan_word_t), .CHAIN(CHAIN_SCAN)) u_scan_shift (
    .fw_clk    (fw_clk),
    .fw_rst_n  (fw_rst_n),
    .cmd       (scan_cmd),
    .cmd_valid (scan_cmd_valid),
    .cmd_ready (scan_cmd_ready),
    .rsp       (scan_rsp),
    .rsp_valid (scan_rsp_valid),
    .busy      (scan_busy),
    .lane_out  (lane_out[LANE_SCAN]),
    .lane_in   (lane_in[LANE_SCAN])
  );

  fw_pin_mux #(.N_FW(N_FW)) u_mux (
    .fw_clk   (fw_clk),
    .fw_rst_n (fw_rst_n),
    .owner    (owner),
    .lane_out (lane_out),
    .lane_in  (lane_in),
    .pins_out (dut_out),
    .pins_in  (dut_in)
  );

endmodule

`default_nettype wire

// ==== bench/pixel_chain_model.sv ====
// Behavioral smart-pixel ASIC chains
// 32-bit configuration chain on config_clk and 16-bit scan chain on bxclk,
// both shifting in at the LSB and returning their MSB, with load counters
`timescale 1ns/10ps
`default_nettype none

module pixel_chain_model import pixel_pkg::*; (
  input  dut_out_t    pins,         // Pins driven by the firmware
  output logic        config_out,
  output logic        scan_out,
  output cfg_word_t   cfg_chain,
  output scan_word_t  scan_chain,
  output logic [31:0] cfg_loads,
  output logic [31:0] scan_loads
);

  cfg_word_t   cfg_q       = '0;
  scan_word_t  scan_q      = '0;
  logic [31:0] cfg_load_n  = '0;
  logic [31:0] scan_load_n = '0;
  logic        cfg_clk;
  logic        scan_clk;
  logic        cfg_load;
  logic        scan_load;

  assign cfg_clk   = pins.config_clk;
  assign scan_clk  = pins.bxclk;
  assign cfg_load  = pins.config_load;
  assign scan_load = pins.scan_load;

  always @(posedge cfg_clk)
    cfg_q <= {cfg_q[30:0], pins.config_in};

  always @(posedge scan_clk)
    scan_q <= {scan_q[14:0], pins.scan_in};   // bxclk is the scan shift clock

  // One count per load pulse
  always @(posedge cfg_load)
    cfg_load_n <= cfg_load_n + 32'd1;

  always @(posedge scan_load)
    scan_load_n <= scan_load_n + 32'd1;

  assign config_out = cfg_q[31];
  assign scan_out   = scan_q[15];
  assign cfg_chain  = cfg_q;
  assign scan_chain = scan_q;
  assign cfg_loads  = cfg_load_n;
  assign scan_loads = scan_load_n;

endmodule

`default_nettype wire

// ==== bench/tb_pixel_fw.sv ====
// Pixel firmware testbench
// Table-driven register accesses against the firmware top with a chain
// model on the ASIC pins and random response stalls
`timescale 1ns/10ps
`default_nettype none

module tb_pixel_fw import pixel_pkg::*; ();

  typedef enum logic [2:0] {
    OP_WR, OP_WR_BP, OP_RD, OP_PINS, OP_OUT, OP_IDLE, OP_MODEL, OP_STALL
  } op_e;

  typedef struct packed {
    op_e         op;
    logic [2:0]  addr;    // Register, or model item for OP_MODEL
    logic [31:0] data;
    logic [31:0] exp;
  } step_t;

  logic        fw_clk;
  logic        fw_rst_n;
  reg_req_t    reg_req;
  logic        reg_req_valid;
  logic        reg_req_ready;
  reg_rsp_t    reg_rsp;
  logic        reg_rsp_valid;
  logic        reg_rsp_ready;
  dut_out_t    dut_out;
  dut_in_t     dut_in;
  logic        m_config_out;
  logic        m_scan_out;
  logic        dnn_0;
  logic        dnn_1;
  logic        ev_toggle;
  cfg_word_t   m_cfg_chain;
  scan_word_t  m_scan_chain;
  logic [31:0] m_cfg_loads;
  logic [31:0] m_scan_loads;
  step_t       steps [$];
  logic        rsp_stall;
  int          req_count;
  int          rsp_count;
  int          cycle_count;
  int          cycle_limit;

  pixel_fw_top uut (
    .fw_clk        (fw_clk),
    .fw_rst_n      (fw_rst_n),
    .reg_req       (reg_req),
    .reg_req_valid (reg_req_valid),
    .reg_req_ready (reg_req_ready),
    .reg_rsp       (reg_rsp),
    .reg_rsp_valid (reg_rsp_valid),
    .reg_rsp_ready (reg_rsp_ready),
    .dut_out       (dut_out),
    .dut_in        (dut_in)
  );

  pixel_chain_model u_asic (
    .pins       (dut_out),
    .config_out (m_config_out),
    .scan_out   (m_scan_out),
    .cfg_chain  (m_cfg_chain),
    .scan_chain (m_scan_chain),
    .cfg_loads  (m_cfg_loads),
    .scan_loads (m_scan_loads)
  );

  // Field order config_out, scan_out, dnn_output_0, dnn_output_1, dn_event_toggle
  assign dut_in = {m_config_out, m_scan_out, dnn_0, dnn_1, ev_toggle};

  initial begin
    fw_clk = 1'b0;
    forever #20 fw_clk = ~fw_clk;
  end

  // ----------------------------------------------------------
  // Handshake counters and run limit
  // ----------------------------------------------------------
  always @(posedge fw_clk) begin
    if (fw_rst_n) begin
      if (reg_req_valid && reg_req_ready) req_count <= req_count + 1;
      if (reg_rsp_valid && reg_rsp_ready) rsp_count <= rsp_count + 1;
    end
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit)
      abort_run("Run did not finish within the cycle limit");
  end

  task automatic abort_run(input string why);
    $display("Regression failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      abort_run("Value mismatch");
    end
  endtask

  task automatic add_step(input op_e op, input logic [2:0] addr,
                          input logic [31:0] data, input logic [31:0] exp);
    steps.push_back('{op, addr, data, exp});
  endtask

  // One host transfer, response ready stalled at random when enabled
  task automatic reg_access(input logic wr, input logic [2:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output int accept_wait);
    logic take;
    accept_wait = 0;
    @(negedge fw_clk);
    reg_req.wr    = wr;
    reg_req.addr  = addr;
    reg_req.wdata = wdata;
    reg_req_valid = 1'b1;
    do begin
      @(negedge fw_clk);
      accept_wait++;
    end while (!reg_rsp_valid);   // Response follows acceptance by one cycle
    reg_req_valid = 1'b0;
    rdata = reg_rsp.rdata;
    do begin
      take = rsp_stall ? 1'($urandom) : 1'b1;
      reg_rsp_ready = take;
      @(negedge fw_clk);
      if (!take)
        check_val("reg_rsp.rdata held", reg_rsp.rdata, rdata);
    end while (!take);
    reg_rsp_ready = 1'b0;
    check_val("reg_rsp_valid after transfer", 32'(reg_rsp_valid), 32'd0);
    check_val("rsp_count", rsp_count, req_count);
  endtask

  task automatic check_model(input logic [2:0] sel, input logic [31:0] exp);
    case (sel)
      3'd0:    check_val("model cfg_chain", m_cfg_chain, exp);
      3'd1:    check_val("model scan_chain", 32'(m_scan_chain), exp);
      3'd2:    check_val("model cfg_loads", m_cfg_loads, exp);
      default: check_val("model scan_loads", m_scan_loads, exp);
    endcase
  endtask

  // ----------------------------------------------------------
  // Stimulus table
  // ----------------------------------------------------------
  task automatic load_table();
    // Reset state
    add_step(OP_OUT, 3'd0, 32'd0, 32'd0);
    add_step(OP_RD, REG_OWNER, 32'd0, 32'd0);
    add_step(OP_RD, REG_MANUAL, 32'd0, 32'd0);
    add_step(OP_RD, REG_STATUS, 32'd0, 32'd0);
    // Manual lane
    add_step(OP_PINS, 3'd0, 32'h5, 32'd0);
    add_step(OP_WR, REG_OWNER, 32'h1, 32'd0);
    add_step(OP_WR, REG_MANUAL, 32'h2d6, 32'd0);      // No clock or load bits
    add_step(OP_OUT, 3'd0, 32'd0, 32'h2d6);
    add_step(OP_RD, REG_MANUAL, 32'd0, 32'h2d6);
    add_step(OP_RD, REG_PIN_IN, 32'd0, 32'h05);
    add_step(OP_PINS, 3'd0, 32'h2, 32'd0);
    add_step(OP_RD, REG_PIN_IN, 32'd0, 32'h02);
    // Configuration chain
    add_step(OP_WR, REG_OWNER, 32'h2, 32'd0);
    add_step(OP_WR, REG_CFG_DATA, 32'ha5c30f96, 32'd0);
    add_step(OP_IDLE, 3'd0, 32'd0, 32'd0);
    add_step(OP_WR, REG_CFG_DATA, 32'h3c5a96e1, 32'd0);
    add_step(OP_IDLE, 3'd0, 32'd0, 32'd0);
    add_step(OP_RD, REG_CFG_DATA, 32'd0, 32'ha5c30f96);
    add_step(OP_MODEL, 3'd0, 32'd0, 32'h3c5a96e1);
    add_step(OP_MODEL, 3'd2, 32'd0, 32'd2);
    // Scan chain, upper write bits ignored
    add_step(OP_WR, REG_OWNER, 32'h4, 32'd0);
    add_step(OP_WR, REG_SCAN_DATA, 32'h1234b70d, 32'd0);
    add_step(OP_IDLE, 3'd0, 32'd0, 32'd0);
    add_step(OP_WR, REG_SCAN_DATA, 32'h00004e29, 32'd0);
    add_step(OP_IDLE, 3'd0, 32'd0, 32'd0);
    add_step(OP_RD, REG_SCAN_DATA, 32'd0, 32'h0000b70d);
    add_step(OP_MODEL, 3'd1, 32'd0, 32'h4e29);
    add_step(OP_MODEL, 3'd3, 32'd0, 32'd2);
    // Invalid owners park the pins
    add_step(OP_WR, REG_OWNER, 32'h0, 32'd0);
    add_step(OP_WR, REG_CFG_DATA, 32'h5aa5c33c, 32'd0);
    add_step(OP_OUT, 3'd0, 32'd0, 32'd0);
    add_step(OP_IDLE, 3'd0, 32'd0, 32'd0);
    add_step(OP_RD, REG_CFG_DATA, 32'd0, 32'd0);
    add_step(OP_WR, REG_OWNER, 32'h3, 32'd0);
    add_step(OP_PINS, 3'd0, 32'h7, 32'd0);
    add_step(OP_WR, REG_CFG_DATA, 32'ha5c30f96, 32'd0);
    add_step(OP_OUT, 3'd0, 32'd0, 32'd0);
    add_step(OP_IDLE, 3'd0, 32'd0, 32'd0);
    add_step(OP_RD, REG_CFG_DATA, 32'd0, 32'd0);
    add_step(OP_RD, REG_PIN_IN, 32'd0, 32'd0);
    add_step(OP_MODEL, 3'd0, 32'd0, 32'h3c5a96e1);
    add_step(OP_MODEL, 3'd2, 32'd0, 32'd2);
    // Back-pressure with response stalls
    add_step(OP_STALL, 3'd0, 32'd1, 32'd0);
    add_step(OP_WR, REG_OWNER, 32'h2, 32'd0);
    add_step(OP_WR, REG_CFG_DATA, 32'h0f1e2d3c, 32'd0);
    add_step(OP_RD, REG_STATUS, 32'd0, 32'h1);
    add_step(OP_WR_BP, REG_CFG_DATA, 32'h8796a5b4, 32'd0);
    add_step(OP_RD, REG_STATUS, 32'd0, 32'h1);
    add_step(OP_IDLE, 3'd0, 32'd0, 32'd0);
    add_step(OP_RD, REG_CFG_DATA, 32'd0, 32'h0f1e2d3c);
    add_step(OP_MODEL, 3'd0, 32'd0, 32'h8796a5b4);
    add_step(OP_MODEL, 3'd2, 32'd0, 32'd4);
    add_step(OP_WR, REG_OWNER, 32'h4, 32'd0);
    add_step(OP_WR, REG_SCAN_DATA, 32'h0000c0de, 32'd0);
    add_step(OP_WR_BP, REG_SCAN_DATA, 32'h0000f00d, 32'd0);
    add_step(OP_IDLE, 3'd0, 32'd0, 32'd0);
    add_step(OP_RD, REG_SCAN_DATA, 32'd0, 32'h0000c0de);
    add_step(OP_MODEL, 3'd1, 32'd0, 32'hf00d);
    add_step(OP_MODEL, 3'd3, 32'd0, 32'd4);
    add_step(OP_RD, REG_OWNER, 32'd0, 32'h4);
    add_step(OP_STALL, 3'd0, 32'd0, 32'd0);
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    step_t       st;
    logic [31:0] rdata;
    int          wait_cyc;
    fw_rst_n      = 1'b0;
    reg_req       = '0;
    reg_req_valid = 1'b0;
    reg_rsp_ready = 1'b0;
    dnn_0         = 1'b0;
    dnn_1         = 1'b0;
    ev_toggle     = 1'b0;
    rsp_stall     = 1'b0;
    void'($urandom(49));
    load_table();
    cycle_limit = steps.size() * (33 * BIT_CYCLES + 50);
    repeat (5) @(posedge fw_clk);
    @(negedge fw_clk);
    fw_rst_n = 1'b1;

    foreach (steps[i]) begin
      st = steps[i];
      case (st.op)
        OP_WR, OP_WR_BP, OP_RD: begin
          reg_access(st.op != OP_RD, st.addr, st.data, rdata, wait_cyc);
          check_val($sformatf("reg_rsp.rdata reg %0d", st.addr), rdata, st.exp);
          if (st.op == OP_WR_BP)
            check_val("accept_stalled", 32'(wait_cyc > BIT_CYCLES), 32'd1);
        end
        OP_PINS: begin
          @(negedge fw_clk);
          {dnn_0, dnn_1, ev_toggle} = st.data[2:0];
        end
        OP_OUT: begin
          repeat (2) @(negedge fw_clk);   // Register plus pad delay
          check_val("dut_out", 32'(dut_out), st.exp);
        end
        OP_IDLE: begin
          do
            reg_access(1'b0, REG_STATUS, 32'd0, rdata, wait_cyc);
          while (rdata[1:0] != 2'b00);
        end
        OP_MODEL: check_model(st.addr, st.exp);
        OP_STALL: rsp_stall = st.data[0];
        default:  abort_run("Unknown operation in the stimulus table");
      endcase
    end

    repeat (2) @(negedge fw_clk);
    if (rsp_count == req_count) begin
      $display("Regression passed");
      $finish;
    end else begin
      check_val("rsp_count at end", rsp_count, req_count);
    end
  end

endmodule

`default_nettype wire

// ==== project.f ====
common/pixel_pkg.sv
chain_engine/chain_shifter.sv
design/pixel_reg_block.sv
design/fw_pin_mux.sv
design/pixel_fw_top.sv
bench/pixel_chain_model.sv
bench/tb_pixel_fw.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the pixel firmware testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_pixel_fw

verilator --binary --timing --assert -Wno-fatal \
  -f project.f --top-module "$TOP" -o "sim_$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build step returned an error"
  exit 1
fi

./obj_dir/"sim_$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Regression failed" "$LOG"; then
  echo "Simulation reported a failing check"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
exit 0
